/* rtl/l2_cache_pkg.sv */
package l2_cache_pkg;

	// Word address geometry
	localparam int L2_ADDR_BITS = 26;
	localparam int L2_SET_BITS = 4;
	localparam int L2_TAG_BITS = L2_ADDR_BITS - L2_SET_BITS;
	localparam int L2_NUM_WAYS = 4;

	// The L1 above has 8 sets, so its tag drops 3 set bits from the address
	localparam int L1_SET_BITS = 3;
	localparam int L1_TAG_BITS = L2_ADDR_BITS - L1_SET_BITS;

	typedef enum logic
	{
		OP_LOAD = 1'b0,
		OP_STORE = 1'b1
	} l2_op_e;

	typedef logic [1:0] l2_way_t;

	typedef struct packed
	{
		logic [L2_TAG_BITS-1:0] tag;
		logic [L2_SET_BITS-1:0] set_index;
	} l2_addr_s;

	// A word address, seen whole or as its tag and set
	typedef union packed
	{
		logic [L2_ADDR_BITS-1:0] line;
		l2_addr_s fields;
	} l2_addr_u;

endpackage

/* rtl/l2_stage_if.sv */
`timescale 1ns/1ps

// One request and its lookup results on the way from one stage to the next
interface l2_stage_if
	import l2_cache_pkg::*;
	#(parameter int SET_BITS = L2_SET_BITS);

	localparam int TAG_BITS = L2_ADDR_BITS - SET_BITS;

	logic valid;
	l2_op_e op;
	l2_addr_u addr;
	logic [31:0] wdata;
	logic hit;
	l2_way_t hit_way;
	l2_way_t replace_way;
	logic [TAG_BITS-1:0] replace_tag;
	logic victim_dirty;
	logic l1_valid;

	modport producer(output valid, op, addr, wdata, hit, hit_way, replace_way,
		replace_tag, victim_dirty, l1_valid);

	modport consumer(input valid, op, addr, wdata, hit, hit_way, replace_way,
		replace_tag, victim_dirty, l1_valid);

endinterface

/* rtl/l2_cache_tag.sv */
`timescale 1ns/1ps

module l2_cache_tag
	import l2_cache_pkg::*;
	#(parameter int SET_BITS = L2_SET_BITS)
	(
	input clk,
	input reset,
	input start,
	input l2_op_e op,
	input l2_addr_u addr,
	input [31:0] wdata,
	input fill_valid,
	input l2_way_t fill_way,
	input l2_addr_u fill_addr,
	l2_stage_if.producer out
	);

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TAG_BITS = L2_ADDR_BITS - SET_BITS;

	logic [TAG_BITS-1:0] tag_mem [L2_NUM_WAYS][NUM_SETS];
	logic [L2_NUM_WAYS-1:0][NUM_SETS-1:0] line_valid;
	l2_way_t [NUM_SETS-1:0] rr_ptr;
	logic hit;
	l2_way_t hit_way;
	l2_way_t replace_way;

	always_comb
	begin
		hit = 1'b0;
		hit_way = '0;
		// Scan downward so the lowest matching way is the one left standing
		for (int w = L2_NUM_WAYS - 1; w >= 0; w--)
		begin
			if (line_valid[w][addr.fields.set_index]
				&& tag_mem[w][addr.fields.set_index] == addr.fields.tag)
			begin
				hit = 1'b1;
				hit_way = l2_way_t'(w);
			end
		end
	end

	// Round-robin victim per set
	assign replace_way = rr_ptr[addr.fields.set_index];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_valid <= '0;
			rr_ptr <= '0;
		end
		else if (fill_valid)
		begin
			line_valid[fill_way][fill_addr.fields.set_index] <= 1'b1;
			rr_ptr[fill_addr.fields.set_index] <= rr_ptr[fill_addr.fields.set_index] + 2'd1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_valid)
			tag_mem[fill_way][fill_addr.fields.set_index] <= fill_addr.fields.tag;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= start;
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			out.op <= op;
			out.addr <= addr;
			out.wdata <= wdata;
			out.hit <= hit;
			out.hit_way <= hit_way;
			out.replace_way <= replace_way;
			out.replace_tag <= tag_mem[replace_way][addr.fields.set_index];
		end
	end

	// Dirty and directory state are looked up by the next stage
	assign out.victim_dirty = 1'b0;
	assign out.l1_valid = 1'b0;

endmodule

/* rtl/l2_cache_dir.sv */
`timescale 1ns/1ps

module l2_cache_dir
	import l2_cache_pkg::*;
	#(parameter int SET_BITS = L2_SET_BITS)
	(
	input clk,
	input reset,
	input fill_valid,
	input l2_way_t fill_way,
	input l2_addr_u fill_addr,
	input l2_op_e fill_op,
	l2_stage_if.consumer in,
	l2_stage_if.producer out
	);

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int KEY_BITS = 2 + SET_BITS;
	localparam int NUM_ENTRIES = 1 << KEY_BITS;

	// Directory entries are keyed by {L2 way, L2 set} and hold the L1 tag of the copy
	logic [NUM_ENTRIES-1:0] dir_valid;
	logic [L1_TAG_BITS-1:0] dir_tag [NUM_ENTRIES];
	logic [L2_NUM_WAYS-1:0][NUM_SETS-1:0] dirty;

	logic [KEY_BITS-1:0] hit_key;
	logic [KEY_BITS-1:0] fill_key;
	logic [L1_TAG_BITS-1:0] req_l1_tag;
	logic [L1_TAG_BITS-1:0] fill_l1_tag;
	logic load_hit;
	logic store_hit;

	assign hit_key = {in.hit_way, in.addr.fields.set_index};
	assign fill_key = {fill_way, fill_addr.fields.set_index};
	assign req_l1_tag = in.addr.line[L2_ADDR_BITS-1:L1_SET_BITS];
	assign fill_l1_tag = fill_addr.line[L2_ADDR_BITS-1:L1_SET_BITS];
	assign load_hit = in.valid && in.hit && in.op == OP_LOAD;
	assign store_hit = in.valid && in.hit && in.op == OP_STORE;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dirty <= '0;
			dir_valid <= '0;
		end
		else if (fill_valid)
		begin
			// A store fill is written right away, a load fill arrives clean
			dirty[fill_way][fill_addr.fields.set_index] <= fill_op == OP_STORE;
			dir_valid[fill_key] <= fill_op == OP_LOAD;
		end
		else
		begin
			if (store_hit)
				dirty[in.hit_way][in.addr.fields.set_index] <= 1'b1;
			if (load_hit)
				dir_valid[hit_key] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_valid && fill_op == OP_LOAD)
			dir_tag[fill_key] <= fill_l1_tag;
		else if (load_hit)
			dir_tag[hit_key] <= req_l1_tag;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			out.valid <= 1'b0;
		else
			out.valid <= in.valid;
	end

	// The lookups read the state as it was before this cycle's update
	always_ff @(posedge clk)
	begin
		out.op <= in.op;
		out.addr <= in.addr;
		out.wdata <= in.wdata;
		out.hit <= in.hit;
		out.hit_way <= in.hit_way;
		out.replace_way <= in.replace_way;
		out.replace_tag <= in.replace_tag;
		out.victim_dirty <= dirty[in.replace_way][in.addr.fields.set_index];
		out.l1_valid <= in.hit && dir_valid[hit_key] && dir_tag[hit_key] == req_l1_tag;
	end

endmodule

/* rtl/l2_cache_data.sv */
`timescale 1ns/1ps

module l2_cache_data
	import l2_cache_pkg::*;
	#(parameter int SET_BITS = L2_SET_BITS)
	(
	input clk,
	input reset,
	l2_stage_if.consumer in,
	input mem_ack,
	input [31:0] mem_rdata,
	output logic mem_req,
	output logic mem_write,
	output logic [L2_ADDR_BITS-1:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic fill_valid,
	output l2_way_t fill_way,
	output l2_addr_u fill_addr,
	output l2_op_e fill_op,
	output logic done,
	output logic [31:0] rsp_data,
	output logic rsp_hit,
	output logic rsp_l1_update
	);

	localparam int TAG_BITS = L2_ADDR_BITS - SET_BITS;
	localparam int NUM_LINES = L2_NUM_WAYS << SET_BITS;

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_WB_REQ = 3'd1;
	localparam logic [2:0] S_WB_END = 3'd2;
	localparam logic [2:0] S_FILL_REQ = 3'd3;
	localparam logic [2:0] S_FILL_END = 3'd4;
	localparam logic [2:0] S_UPDATE = 3'd5;

	logic [31:0] data_mem [NUM_LINES];
	logic [2:0] state;
	l2_op_e miss_op;
	l2_addr_u miss_addr;
	logic [31:0] miss_wdata;
	l2_way_t miss_way;
	logic [TAG_BITS-1:0] victim_tag;
	logic [31:0] fill_data;
	logic [31:0] update_data;
	l2_addr_u victim_addr;
	logic [SET_BITS+1:0] hit_line;
	logic [SET_BITS+1:0] miss_line;
	logic hit_done;
	logic miss_start;

	assign hit_line = {in.hit_way, in.addr.fields.set_index};
	assign miss_line = {miss_way, miss_addr.fields.set_index};
	assign hit_done = in.valid && in.hit;
	assign miss_start = state == S_IDLE && in.valid && !in.hit;

	// The victim goes back under its old tag in the same set
	always_comb
	begin
		victim_addr.fields.tag = victim_tag;
		victim_addr.fields.set_index = miss_addr.fields.set_index;
	end

	assign mem_req = state == S_WB_REQ || state == S_FILL_REQ;
	assign mem_write = state == S_WB_REQ;
	assign mem_addr = mem_write ? victim_addr.line : miss_addr.line;
	assign mem_wdata = data_mem[miss_line];

	assign fill_valid = state == S_UPDATE;
	assign fill_way = miss_way;
	assign fill_addr = miss_addr;
	assign fill_op = miss_op;
	assign done = hit_done || fill_valid;

	// Lines are a single word, so a store miss simply replaces the filled word
	assign update_data = miss_op == OP_STORE ? miss_wdata : fill_data;

	// Each memory transaction waits for mem_ack to fall before moving on
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= S_IDLE;
		else
		begin
			case (state)
				S_IDLE:
					if (miss_start)
						state <= in.victim_dirty ? S_WB_REQ : S_FILL_REQ;
				S_WB_REQ:
					if (mem_ack)
						state <= S_WB_END;
				S_WB_END:
					if (!mem_ack)
						state <= S_FILL_REQ;
				S_FILL_REQ:
					if (mem_ack)
						state <= S_FILL_END;
				S_FILL_END:
					if (!mem_ack)
						state <= S_UPDATE;
				default:
					state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_start)
		begin
			miss_op <= in.op;
			miss_addr <= in.addr;
			miss_wdata <= in.wdata;
			miss_way <= in.replace_way;
			victim_tag <= in.replace_tag;
		end
		if (state == S_FILL_REQ && mem_ack)
			fill_data <= mem_rdata;
	end

	always_ff @(posedge clk)
	begin
		if (hit_done)
		begin
			if (in.op == OP_STORE)
			begin
				data_mem[hit_line] <= in.wdata;
				rsp_data <= in.wdata;
			end
			else
				rsp_data <= data_mem[hit_line];
			rsp_hit <= 1'b1;
			// A store to a line that L1 holds means L1 must take the new word too
			rsp_l1_update <= in.op == OP_STORE && in.l1_valid;
		end
		else if (fill_valid)
		begin
			data_mem[miss_line] <= update_data;
			rsp_data <= update_data;
			rsp_hit <= 1'b0;
			rsp_l1_update <= 1'b0;
		end
	end

endmodule

/* rtl/l2_cache.sv */
`timescale 1ns/1ps

module l2_cache
	import l2_cache_pkg::*;
	#(parameter int SET_BITS = L2_SET_BITS)
	(
	input clk,
	input reset,
	input req,
	input l2_op_e op,
	input [L2_ADDR_BITS-1:0] addr,
	input [31:0] wdata,
	output logic ack,
	output logic [31:0] rsp_data,
	output logic rsp_hit,
	output logic rsp_l1_update,
	output logic mem_req,
	output logic mem_write,
	output logic [L2_ADDR_BITS-1:0] mem_addr,
	output logic [31:0] mem_wdata,
	input mem_ack,
	input [31:0] mem_rdata
	);

	logic busy;
	logic start;
	logic accept;
	logic done;
	logic fill_valid;
	l2_way_t fill_way;
	l2_addr_u fill_addr;
	l2_op_e fill_op;

	l2_stage_if #(.SET_BITS(SET_BITS)) tag_to_dir();
	l2_stage_if #(.SET_BITS(SET_BITS)) dir_to_data();

	// Only one request in flight, and the client must finish its handshake first
	assign accept = req && !ack && !busy;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			start <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			start <= accept;
			if (accept)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			// ack holds until the client lets go of req
			if (done)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
		end
	end

	l2_cache_tag #(.SET_BITS(SET_BITS)) tag0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.addr(addr),
		.wdata(wdata),
		.fill_valid(fill_valid),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.out(tag_to_dir)
	);

	l2_cache_dir #(.SET_BITS(SET_BITS)) dir0 (
		.clk(clk),
		.reset(reset),
		.fill_valid(fill_valid),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.fill_op(fill_op),
		.in(tag_to_dir),
		.out(dir_to_data)
	);

	l2_cache_data #(.SET_BITS(SET_BITS)) data0 (
		.clk(clk),
		.reset(reset),
		.in(dir_to_data),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.fill_valid(fill_valid),
		.fill_way(fill_way),
		.fill_addr(fill_addr),
		.fill_op(fill_op),
		.done(done),
		.rsp_data(rsp_data),
		.rsp_hit(rsp_hit),
		.rsp_l1_update(rsp_l1_update)
	);

endmodule

/* bench/l2_cache_tb.sv */
`timescale 1ns/1ps

module l2_cache_tb
	import l2_cache_pkg::*;
	();

	localparam int SET_BITS = 4;
	localparam int NUM_REQS = 60;
	localparam int NUM_DIRECTED = 13;
	localparam int MAX_CYCLES = NUM_REQS * 40;

	logic clk = 1'b0;
	logic reset;
	logic req;
	l2_op_e op;
	logic [L2_ADDR_BITS-1:0] addr;
	logic [31:0] wdata;
	logic ack;
	logic [31:0] rsp_data;
	logic rsp_hit;
	logic rsp_l1_update;
	logic mem_req;
	logic mem_write;
	logic [L2_ADDR_BITS-1:0] mem_addr;
	logic [31:0] mem_wdata;
	logic mem_ack = 1'b0;
	logic [31:0] mem_rdata = '0;

	integer seed = 34188;
	int cycle_count = 0;

	// Memory model state, owned by the memory process
	logic [31:0] mem_store [logic [L2_ADDR_BITS-1:0]];
	logic [2:0] delay_table [256];
	logic [7:0] delay_index = '0;
	int mem_wait = 0;
	int mem_reads = 0;
	int mem_writes = 0;
	int last_wr_reads = 0;
	logic [L2_ADDR_BITS-1:0] last_wr_addr;
	logic [31:0] last_wr_data;

	// Reference cache: the word a load must return, plus tags, dirty bits and directory
	logic [31:0] shadow [logic [L2_ADDR_BITS-1:0]];
	bit [L2_TAG_BITS-1:0] ref_tag [16][4];
	bit ref_valid [16][4];
	bit ref_dirty [16][4];
	bit ref_dir [16][4];
	bit [1:0] ref_rr [16];

	l2_cache #(.SET_BITS(SET_BITS)) dut0 (
		.clk(clk),
		.reset(reset),
		.req(req),
		.op(op),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rsp_data(rsp_data),
		.rsp_hit(rsp_hit),
		.rsp_l1_update(rsp_l1_update),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	always #5 clk = ~clk;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		stop_with_failure($sformatf("[ERROR] time %0t: %s expected %h actual %h",
			$time, name, expected, actual));
	endtask

	function automatic logic [31:0] default_word(input logic [L2_ADDR_BITS-1:0] a);
		return {6'b0, a} ^ 32'h5A5A_0000;
	endfunction

	function automatic logic [31:0] expected_value(input logic [L2_ADDR_BITS-1:0] a);
		if (shadow.exists(a))
			return shadow[a];
		return default_word(a);
	endfunction

	function automatic logic [L2_ADDR_BITS-1:0] make_addr(input int tag, input logic [3:0] set);
		return {22'(tag), set};
	endfunction

	mem_req_waits: assert property (@(posedge clk) disable iff (reset) $rose(mem_req) |-> !mem_ack)
		else stop_with_failure("mem_req rose while mem_ack was still high");
	ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
		else stop_with_failure("ack rose while req was low");
	ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
		$fell(ack) |-> !$past(req))
		else stop_with_failure("ack fell before req was dropped");
	l1_update_on_store_hit: assert property (@(posedge clk) disable iff (reset)
		ack |-> (!rsp_l1_update || (rsp_hit && op == OP_STORE)))
		else stop_with_failure("rsp_l1_update was raised by something other than a store hit");

	// Memory answers each request after 1 to 4 cycles, then waits for mem_req to drop
	always @(posedge clk)
	begin
		if (reset)
		begin
			mem_ack <= 1'b0;
			mem_wait = 0;
		end
		else if (mem_req && !mem_ack)
		begin
			if (mem_wait == 0)
			begin
				mem_wait = int'(delay_table[delay_index]);
				delay_index = delay_index + 8'd1;
			end
			mem_wait = mem_wait - 1;
			if (mem_wait == 0)
			begin
				mem_ack <= 1'b1;
				if (mem_write)
				begin
					mem_store[mem_addr] = mem_wdata;
					last_wr_addr = mem_addr;
					last_wr_data = mem_wdata;
					last_wr_reads = mem_reads;
					mem_writes = mem_writes + 1;
				end
				else
				begin
					mem_rdata <= mem_store.exists(mem_addr) ? mem_store[mem_addr]
						: default_word(mem_addr);
					mem_reads = mem_reads + 1;
				end
			end
		end
		else if (!mem_req)
			mem_ack <= 1'b0;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
			stop_with_failure("timeout: the requests did not finish within the cycle limit");
	end

	// One full four-phase request, checked against the reference cache
	task automatic run_request(input l2_op_e req_op, input logic [L2_ADDR_BITS-1:0] req_addr,
		input logic [31:0] req_wdata, input int hold_cycles);
		logic [3:0] set_idx;
		logic exp_hit;
		logic exp_wb;
		logic exp_l1;
		l2_way_t way;
		logic [L2_ADDR_BITS-1:0] victim;
		logic [31:0] exp_data;
		int latency;
		int reads_before;
		int writes_before;

		set_idx = req_addr[3:0];
		exp_hit = 1'b0;
		way = ref_rr[set_idx];
		for (int w = 3; w >= 0; w--)
		begin
			if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == req_addr[25:4])
			begin
				exp_hit = 1'b1;
				way = l2_way_t'(w);
			end
		end
		exp_wb = !exp_hit && ref_valid[set_idx][way] && ref_dirty[set_idx][way];
		exp_l1 = exp_hit && req_op == OP_STORE && ref_dir[set_idx][way];
		victim = {ref_tag[set_idx][way], set_idx};
		exp_data = req_op == OP_STORE ? req_wdata : expected_value(req_addr);
		reads_before = mem_reads;
		writes_before = mem_writes;

		@(posedge clk);
		op <= req_op;
		addr <= req_addr;
		wdata <= req_wdata;
		req <= 1'b1;
		latency = 0;
		@(negedge clk);
		while (!ack)
		begin
			@(negedge clk);
			latency++;
		end

		assert (rsp_hit == exp_hit) else report_mismatch("rsp_hit", 32'(exp_hit), 32'(rsp_hit));
		assert (rsp_data == exp_data) else report_mismatch("rsp_data", exp_data, rsp_data);
		assert (rsp_l1_update == exp_l1)
			else report_mismatch("rsp_l1_update", 32'(exp_l1), 32'(rsp_l1_update));
		if (exp_hit)
		begin
			assert (latency == 4) else report_mismatch("hit latency", 32'd4, 32'(latency));
		end
		else
		begin
			assert (mem_reads - reads_before == 1)
				else report_mismatch("fill reads", 32'd1, 32'(mem_reads - reads_before));
			assert (mem_writes - writes_before == int'(exp_wb))
				else report_mismatch("writebacks", 32'(exp_wb), 32'(mem_writes - writes_before));
			if (exp_wb)
			begin
				assert (last_wr_addr == victim)
					else report_mismatch("mem_addr", 32'(victim), 32'(last_wr_addr));
				assert (last_wr_data == expected_value(victim))
					else report_mismatch("mem_wdata", expected_value(victim), last_wr_data);
				assert (last_wr_reads == reads_before)
					else stop_with_failure("the writeback came after the fill read");
			end
		end

		// A client that keeps req high must see ack held
		repeat (hold_cycles)
		begin
			@(negedge clk);
			assert (ack) else stop_with_failure("ack dropped while req was still high");
		end
		@(posedge clk);
		req <= 1'b0;
		do
			@(negedge clk);
		while (ack);

		// A hit leaves the memory bus idle through the whole handshake
		if (exp_hit)
		begin
			assert (!mem_req && mem_reads == reads_before && mem_writes == writes_before)
				else stop_with_failure("a cache hit issued a memory request");
		end

		if (req_op == OP_STORE)
			shadow[req_addr] = req_wdata;
		if (exp_hit)
		begin
			if (req_op == OP_STORE)
				ref_dirty[set_idx][way] = 1'b1;
			else
				ref_dir[set_idx][way] = 1'b1;
		end
		else
		begin
			ref_tag[set_idx][way] = req_addr[25:4];
			ref_valid[set_idx][way] = 1'b1;
			ref_dirty[set_idx][way] = req_op == OP_STORE;
			ref_dir[set_idx][way] = req_op == OP_LOAD;
			ref_rr[set_idx] = ref_rr[set_idx] + 2'd1;
		end
	endtask

	initial
	begin
		logic [3:0] rand_set;
		int rand_tag;
		l2_op_e rand_op;
		logic [31:0] rand_data;

		reset = 1'b1;
		req = 1'b0;
		op = OP_LOAD;
		addr = '0;
		wdata = '0;
		for (int i = 0; i < 256; i++)
			delay_table[i] = 3'(1 + $unsigned($random(seed)) % 4);
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		assert (!ack && !mem_req) else stop_with_failure("ack or mem_req high after reset");

		// Set 2 fills up, then evictions walk the round-robin ways
		run_request(OP_LOAD, make_addr(1, 4'd2), 32'h0, 0);
		run_request(OP_LOAD, make_addr(1, 4'd2), 32'h0, 0);
		run_request(OP_STORE, make_addr(1, 4'd2), 32'h1111_0001, 0);
		run_request(OP_LOAD, make_addr(1, 4'd2), 32'h0, 0);
		run_request(OP_STORE, make_addr(2, 4'd2), 32'h2222_0002, 0);
		run_request(OP_STORE, make_addr(2, 4'd2), 32'h2222_0003, 0);
		run_request(OP_LOAD, make_addr(2, 4'd2), 32'h0, 3);
		run_request(OP_LOAD, make_addr(3, 4'd2), 32'h0, 0);
		run_request(OP_LOAD, make_addr(4, 4'd2), 32'h0, 0);
		run_request(OP_LOAD, make_addr(5, 4'd2), 32'h0, 0);
		run_request(OP_LOAD, make_addr(1, 4'd2), 32'h0, 0);
		run_request(OP_STORE, make_addr(6, 4'd2), 32'h6666_0006, 0);
		run_request(OP_STORE, make_addr(6, 4'd2), 32'h6666_0007, 0);

		for (int i = 0; i < NUM_REQS - NUM_DIRECTED; i++)
		begin
			rand_set = ($random(seed) & 1) ? 4'd5 : 4'd2;
			rand_tag = 1 + $unsigned($random(seed)) % 6;
			rand_op = ($random(seed) & 1) ? OP_STORE : OP_LOAD;
			rand_data = $random(seed);
			run_request(rand_op, make_addr(rand_tag, rand_set), rand_data, 0);
		end

		$display("sim passed");
		$finish;
	end

endmodule

/* verilog.f */
rtl/l2_cache_pkg.sv
rtl/l2_stage_if.sv
rtl/l2_cache_tag.sv
rtl/l2_cache_dir.sv
rtl/l2_cache_data.sv
rtl/l2_cache.sv
bench/l2_cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= l2_cache_tb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= sim passed
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
